// ==== logic/rram_access_ctrl.sv ====
// turns one granted request into the macro strobe sequence and returns read data
module rram_access_ctrl #(
    parameter int unsigned SET_CYC   = 4,
    parameter int unsigned RESET_CYC = 4
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  rram_pkg::rram_req_t         req_i,
    output rram_pkg::rri_t              rri_o,
    input  rram_pkg::rro_t              rro_i,
    output logic [rram_pkg::DATA_W-1:0] dout_o,
    output logic                        dout_ready_o,
    output logic                        busy_o
);
    import rram_pkg::*;

    localparam int unsigned MAX_CYC = (SET_CYC > RESET_CYC) ? SET_CYC : RESET_CYC;
    localparam int unsigned CNT_W   = $clog2(MAX_CYC + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WR_SET,    // enable cycle, then SET_CYC cycles of SET
        S_WR_RESET,
        S_RD_WAIT,
        S_DONE       // read data out while already idle
    } state_e;

    state_e              state_q;
    logic [CNT_W-1:0]    cnt_q;    // phase counter
    logic                rst_q;
    logic [ADDR_X_W-1:0] xadr_q;
    logic [ADDR_Y_W-1:0] yadr_q;
    logic [DATA_W-1:0]   data_q;
    logic [DATA_W-1:0]   dout_q;
    logic                accept;
    logic                in_wr;
    logic                in_rd;
    logic                busy;

    assign in_wr = (state_q == S_WR_SET) || (state_q == S_WR_RESET);
    assign in_rd = (state_q == S_RD_WAIT);
    assign busy  = in_wr || in_rd;

    // unknown nonzero codes are dropped like any request seen while busy
    assign accept = !busy && ((req_i.cmd == CMD_READ) || (req_i.cmd == CMD_WRITE));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_WR_SET: begin
                    if (cnt_q == CNT_W'(SET_CYC)) begin
                        state_q <= S_WR_RESET;
                        cnt_q   <= CNT_W'(1);
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_WR_RESET: begin
                    if (cnt_q == CNT_W'(RESET_CYC)) begin
                        state_q <= S_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_RD_WAIT: begin
                    if (rro_i.RDONE) begin
                        state_q <= S_DONE;  // latency set by the macro
                    end
                end
                default: begin
                    // idle and done both take the next command
                    cnt_q <= '0;
                    if (accept) begin
                        if (req_i.cmd == CMD_WRITE) begin
                            state_q <= S_WR_SET;
                        end else begin
                            state_q <= S_RD_WAIT;
                        end
                    end else begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // macro reset held until the first clock after reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_q <= 1'b1;
        end else begin
            rst_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            xadr_q <= req_i.xadr;
            yadr_q <= req_i.yadr;
            data_q <= req_i.data;
        end
        if (in_rd && rro_i.RDONE) begin
            dout_q <= {rro_i.DOUT_CR, rro_i.DOUT};  // cr bits back on top
        end
    end

    always_comb begin
        rri_o           = '0;
        rri_o.XADR      = xadr_q;
        rri_o.YADR      = yadr_q;
        rri_o.DIN       = data_q[IO_W-1:0];
        rri_o.DIN_CR    = data_q[DATA_W-1 -: CR_W];
        rri_o.CFG_MACRO = CFG_DEFAULT;
        rri_o.RST       = rst_q;
        rri_o.XE        = busy;
        rri_o.YE        = busy;
        rri_o.CE        = busy;
        rri_o.SET       = (state_q == S_WR_SET) && (cnt_q != '0);
        rri_o.RESET     = (state_q == S_WR_RESET);
        rri_o.READ      = in_rd;
        rri_o.AE        = in_rd;
    end

    assign dout_o       = dout_q;
    assign dout_ready_o = (state_q == S_DONE);
    assign busy_o       = busy;

    a_set_reset_excl : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(rri_o.SET && rri_o.RESET)
    );

    a_read_not_in_write : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rri_o.READ |-> !(rri_o.SET || rri_o.RESET)
    );

endmodule

// ==== logic/rram_bist_engine.sv ====
// self-test sequencer; writes an address pattern, reads it back and flags any mismatch
module rram_bist_engine #(
    parameter int unsigned BIST_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        bist_enable_i,
    input  logic                        grant_i,
    input  logic                        busy_i,
    input  logic [rram_pkg::DATA_W-1:0] dout_i,
    input  logic                        dout_ready_i,
    output rram_pkg::rram_req_t         req_o,
    output logic                        bist_busy_o,
    output logic                        bist_fail_o
);
    import rram_pkg::*;

    localparam int unsigned IDX_W = (BIST_DEPTH > 1) ? $clog2(BIST_DEPTH) : 1;
    localparam int unsigned REP   = DATA_W / ADDR_X_W + 1;

    typedef enum logic [1:0] {
        B_IDLE,
        B_ISSUE,  // request held until the controller takes it
        B_WAIT
    } bstate_e;

    bstate_e             state_q;
    logic                rd_phase_q;  // 0 write pass, 1 read pass
    logic                en_q;
    logic                fail_q;
    logic [IDX_W-1:0]    idx_q;
    logic [ADDR_X_W-1:0] xadr;
    logic                start;
    logic                last;
    logic                step;

    // address repeated over the word, odd addresses inverted
    function automatic logic [DATA_W-1:0] pattern(input logic [ADDR_X_W-1:0] xa);
        logic [REP*ADDR_X_W-1:0] rep;
        rep = {REP{xa}};
        return xa[0] ? ~rep[DATA_W-1:0] : rep[DATA_W-1:0];
    endfunction

    assign xadr  = ADDR_X_W'(idx_q);
    assign start = bist_enable_i && !en_q;
    assign last  = (idx_q == IDX_W'(BIST_DEPTH - 1));

    // reads end with the data pulse, writes when busy drops
    assign step = (state_q == B_WAIT) && (rd_phase_q ? dout_ready_i : !busy_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= B_IDLE;
            rd_phase_q <= 1'b0;
            idx_q      <= '0;
            en_q       <= 1'b0;
            fail_q     <= 1'b0;
        end else begin
            en_q <= bist_enable_i;
            if (start) begin
                state_q    <= B_ISSUE;
                rd_phase_q <= 1'b0;
                idx_q      <= '0;
                fail_q     <= 1'b0;  // new run, old result gone
            end else if (!bist_enable_i) begin
                state_q <= B_IDLE;   // run abandoned
            end else begin
                case (state_q)
                    B_ISSUE: begin
                        if (grant_i && !busy_i) begin
                            state_q <= B_WAIT;
                        end
                    end
                    B_WAIT: begin
                        if (step) begin
                            if (rd_phase_q && (dout_i != pattern(xadr))) begin
                                fail_q <= 1'b1;
                            end
                            if (!last) begin
                                idx_q   <= idx_q + 1'b1;
                                state_q <= B_ISSUE;
                            end else if (!rd_phase_q) begin
                                rd_phase_q <= 1'b1;
                                idx_q      <= '0;
                                state_q    <= B_ISSUE;
                            end else begin
                                state_q <= B_IDLE;  // last compare done
                            end
                        end
                    end
                    default: begin
                        state_q <= B_IDLE;
                    end
                endcase
            end
        end
    end

    always_comb begin
        req_o      = '0;
        req_o.xadr = xadr;
        req_o.yadr = '0;                // single column
        req_o.data = pattern(xadr);
        if (state_q == B_ISSUE) begin
            if (rd_phase_q) begin
                req_o.cmd = CMD_READ;
            end else begin
                req_o.cmd = CMD_WRITE;
            end
        end else begin
            req_o.cmd = CMD_NOP;
        end
    end

    assign bist_busy_o = (state_q != B_IDLE);
    assign bist_fail_o = fail_q;

endmodule

// ==== logic/rram_pkg.sv ====
// shared widths, command codes and macro bundles; imported by every RRAM controller block
package rram_pkg;

    // address split of the macro
    localparam int unsigned ADDR_X_W = 13;  // word-line address
    localparam int unsigned ADDR_Y_W = 5;   // column address

    // data layout
    localparam int unsigned UDATA_W  = 128;                // user word
    localparam int unsigned CR_W     = 2;                  // redundancy bits
    localparam int unsigned TDATA_W  = 16 + CR_W;          // parity plus redundancy
    localparam int unsigned DATA_W   = UDATA_W + TDATA_W;  // full word
    localparam int unsigned IO_W     = DATA_W - CR_W;      // width of DIN and DOUT

    localparam int unsigned CFG_W    = 210;

    // fixed macro trim word, nothing overrides it
    localparam logic [CFG_W-1:0] CFG_DEFAULT = CFG_W'(72'h00_1c30_0a50_0000_0f3);

    // zero must stay NOP, requesters idle at zero
    typedef enum logic [3:0] {
        CMD_NOP   = 4'h0,
        CMD_READ  = 4'h1,
        CMD_WRITE = 4'h2
    } cmd_e;

    // one access request, 168 bits
    typedef struct packed {
        cmd_e                cmd;
        logic [ADDR_X_W-1:0] xadr;
        logic [ADDR_Y_W-1:0] yadr;
        logic [DATA_W-1:0]   data;  // {tag, user}
    } rram_req_t;

    // macro inputs
    typedef struct packed {
        logic [ADDR_X_W-1:0] XADR;
        logic [ADDR_Y_W-1:0] YADR;
        logic [IO_W-1:0]     DIN;
        logic [CR_W-1:0]     DIN_CR;     // top bits of the full word
        logic [CFG_W-1:0]    CFG_MACRO;
        logic                SET;
        logic                RESET;
        logic                RST;
        logic                REDEN;
        logic                IFREN;
        logic                IFREN1;
        logic                XE;
        logic                YE;
        logic                READ;
        logic                PCH_EXT;
        logic                AE;
        logic                CE;
    } rri_t;

    // macro outputs, 147 bits
    typedef struct packed {
        logic                RDONE;
        logic [IO_W-1:0]     DOUT;
        logic [CR_W-1:0]     DOUT_CR;
    } rro_t;

endpackage

// ==== logic/rram_req_arbiter.sv ====
// selects the user port or the self-test engine as the controller's request source
module rram_req_arbiter (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                bist_enable_i,
    input  rram_pkg::rram_req_t user_req_i,
    input  rram_pkg::rram_req_t bist_req_i,
    input  logic                busy_i,
    output rram_pkg::rram_req_t grant_req_o,
    output logic                bist_grant_o
);

    logic bist_grant_q;

    // grant tracks bist_enable but only moves between accesses
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bist_grant_q <= 1'b0;  // user port owns the bus out of reset
        end else if (!busy_i) begin
            bist_grant_q <= bist_enable_i;
        end
    end

    // the loser's request is simply not seen by the controller
    assign grant_req_o  = bist_grant_q ? bist_req_i : user_req_i;
    assign bist_grant_o = bist_grant_q;

    // an access in flight keeps its owner until the controller goes idle
    a_grant_stable_busy : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        busy_i |=> $stable(bist_grant_o)
    );

endmodule

// ==== logic/rram_wrapper.sv ====
// top level of the RRAM controller; connects user port, self-test and macro bundles
module rram_wrapper #(
    parameter int unsigned SET_CYC    = 4,
    parameter int unsigned RESET_CYC  = 4,
    parameter int unsigned BIST_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  rram_pkg::rram_req_t         user_req_i,
    input  logic                        bist_enable_i,
    output logic [rram_pkg::DATA_W-1:0] trc_dout_o,
    output logic                        trc_dout_ready_o,
    output logic                        trc_busy_o,
    output logic                        bist_busy_o,
    output logic                        bist_fail_o,
    output rram_pkg::rri_t              rri_o,
    input  rram_pkg::rro_t              rro_i
);
    import rram_pkg::*;

    rram_req_t bist_req;   // from the self-test engine
    rram_req_t grant_req;  // whichever source holds the grant
    logic      bist_grant;

    rram_req_arbiter u_arbiter (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .bist_enable_i (bist_enable_i),
        .user_req_i    (user_req_i),
        .bist_req_i    (bist_req),
        .busy_i        (trc_busy_o),
        .grant_req_o   (grant_req),
        .bist_grant_o  (bist_grant)
    );

    rram_access_ctrl #(
        .SET_CYC   (SET_CYC),
        .RESET_CYC (RESET_CYC)
    ) u_access_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (grant_req),
        .rri_o        (rri_o),
        .rro_i        (rro_i),
        .dout_o       (trc_dout_o),
        .dout_ready_o (trc_dout_ready_o),
        .busy_o       (trc_busy_o)
    );

    // read data and status go to both sides, only the grant holder uses them
    rram_bist_engine #(
        .BIST_DEPTH (BIST_DEPTH)
    ) u_bist_engine (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .bist_enable_i (bist_enable_i),
        .grant_i       (bist_grant),
        .busy_i        (trc_busy_o),
        .dout_i        (trc_dout_o),
        .dout_ready_i  (trc_dout_ready_o),
        .req_o         (bist_req),
        .bist_busy_o   (bist_busy_o),
        .bist_fail_o   (bist_fail_o)
    );

endmodule

// ==== verification/rram_macro_model.sv ====
// behavioral RRAM macro for simulation; sparse word store, random read latency, optional stuck bit
module rram_macro_model #(
    parameter logic [31:0] SEED      = 32'h311f,
    parameter int unsigned STUCK_BIT = 5
) (
    input  logic           clk,
    input  rram_pkg::rri_t rri_i,
    output rram_pkg::rro_t rro_o,
    input  logic           stuck_i   // pulls STUCK_BIT low on read data
);
    import rram_pkg::*;

    logic [DATA_W-1:0]            mem [logic [ADDR_X_W+ADDR_Y_W-1:0]];
    logic [ADDR_X_W+ADDR_Y_W-1:0] key;
    logic [31:0]                  rng_q     = SEED;
    logic [2:0]                   wait_q    = 3'd0;
    logic                         reading_q = 1'b0;
    logic                         rdone_q   = 1'b0;
    logic [DATA_W-1:0]            rdata_q   = '0;
    logic [DATA_W-1:0]            word_out;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    assign key = {rri_i.XADR, rri_i.YADR};

    always @(posedge clk) begin : macro_seq
        logic [2:0] left;
        // latency drawn when READ first shows up, 1 to 6 cycles
        left = reading_q ? wait_q : 3'(rng_q % 6) + 3'd1;
        rdone_q <= 1'b0;
        if (rri_i.CE && rri_i.SET) begin
            mem[key] = {rri_i.DIN_CR, rri_i.DIN};
        end
        if (rri_i.CE && rri_i.READ && !rdone_q) begin
            if (!reading_q) begin
                rng_q <= xorshift(rng_q);
            end
            if (left == 3'd1) begin
                rdone_q   <= 1'b1;
                rdata_q   <= mem.exists(key) ? mem[key] : '0;  // unwritten words read as zero
                reading_q <= 1'b0;
            end else begin
                wait_q    <= left - 3'd1;
                reading_q <= 1'b1;
            end
        end
    end

    always_comb begin
        word_out = rdata_q;
        if (stuck_i) begin
            word_out[STUCK_BIT] = 1'b0;
        end
        rro_o.RDONE   = rdone_q;
        rro_o.DOUT    = word_out[IO_W-1:0];
        rro_o.DOUT_CR = word_out[DATA_W-1 -: CR_W];
    end

endmodule

// ==== verification/tb_rram_wrapper.sv ====
// testbench for the RRAM controller top; random user traffic, write timing and self-test runs
module tb_rram_wrapper;
    import rram_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int BIST_DEPTH = 16;
    localparam int PHASE_CYC  = 4;
    localparam int WR_BUSY    = 1 + 2 * PHASE_CYC;  // enable cycle, SET, RESET
    localparam int N_RW       = 16;
    localparam int N_TIMING   = 8;
    localparam int WAIT_LIMIT = 20;                  // cycles per access
    // every access of the run, self-test passes included
    localparam int TOTAL_OPS  = 2 * N_RW + N_TIMING + 7 * BIST_DEPTH + 2;

    logic              clk;
    logic              arst_n;
    rram_req_t         user_req;
    logic              bist_enable;
    logic              stuck;
    logic [DATA_W-1:0] trc_dout;
    logic              trc_dout_ready;
    logic              trc_busy;
    logic              bist_busy;
    logic              bist_fail;
    rri_t              rri;
    rro_t              rro;

    logic [31:0]       rng_state;
    logic [DATA_W-1:0] ref_mem [logic [ADDR_X_W+ADDR_Y_W-1:0]];
    int                errors;
    int                checks;
    int                tests;
    int                tests_failed;
    int                err_mark;

    rram_wrapper #(
        .SET_CYC    (PHASE_CYC),
        .RESET_CYC  (PHASE_CYC),
        .BIST_DEPTH (BIST_DEPTH)
    ) uut (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .user_req_i       (user_req),
        .bist_enable_i    (bist_enable),
        .trc_dout_o       (trc_dout),
        .trc_dout_ready_o (trc_dout_ready),
        .trc_busy_o       (trc_busy),
        .bist_busy_o      (bist_busy),
        .bist_fail_o      (bist_fail),
        .rri_o            (rri),
        .rro_i            (rro)
    );

    rram_macro_model u_macro (
        .clk     (clk),
        .rri_i   (rri),
        .rro_o   (rro),
        .stuck_i (stuck)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [159:0] r;
        r = '0;
        for (int i = 0; i < 5; i++) begin
            r = {r[127:0], next_rand()};
        end
        return r[DATA_W-1:0];
    endfunction

    // self-test word, x address repeated from bit 0 up, odd addresses inverted
    function automatic logic [DATA_W-1:0] bist_pattern(input int xa);
        logic [ADDR_X_W-1:0] a;
        logic [DATA_W-1:0]   w;
        a = ADDR_X_W'(xa);
        for (int i = 0; i < DATA_W; i++) begin
            w[i] = a[i % ADDR_X_W];
        end
        return a[0] ? ~w : w;
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_X_W-1:0] x,
                                                      input logic [ADDR_Y_W-1:0] y);
        if (ref_mem.exists({x, y})) begin
            return ref_mem[{x, y}];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // one user access from a falling edge; counts busy, SET and RESET cycles
    task automatic access(input cmd_e cmd, input logic [ADDR_X_W-1:0] x,
                          input logic [ADDR_Y_W-1:0] y, input logic [DATA_W-1:0] wdata,
                          output logic [DATA_W-1:0] rdata, output int busy_n,
                          output int set_n, output int reset_n);
        int cyc;
        cyc     = 0;
        busy_n  = 0;
        set_n   = 0;
        reset_n = 0;
        while (trc_busy && cyc < WAIT_LIMIT) begin
            cyc++;
            @(negedge clk);
        end
        user_req.cmd  = cmd;
        user_req.xadr = x;
        user_req.yadr = y;
        user_req.data = wdata;
        @(negedge clk);
        user_req.cmd = CMD_NOP;
        while (trc_busy && busy_n < WAIT_LIMIT) begin
            busy_n++;
            set_n   += int'(rri.SET);
            reset_n += int'(rri.RESET);
            @(negedge clk);
        end
        checks++;
        assert (!trc_busy && (cmd != CMD_READ || trc_dout_ready)) else begin
            $display("access at x %0d y %0d did not complete in time", x, y);
            errors++;
        end
        rdata = trc_dout;
        if (cmd == CMD_WRITE) begin
            ref_mem[{x, y}] = wdata;
        end
    endtask

    // full self-test run; with poke set, user writes go out at every idle slot
    task automatic run_bist(input bit poke, input logic [ADDR_X_W-1:0] x,
                            input logic [ADDR_Y_W-1:0] y);
        int cyc;
        cyc = 0;
        bist_enable   = 1'b1;
        user_req.xadr = x;
        user_req.yadr = y;
        user_req.data = rand_word();
        repeat (2) @(negedge clk);  // grant has moved to the self-test
        while (bist_busy && cyc < 2 * BIST_DEPTH * WAIT_LIMIT) begin
            user_req.cmd = (poke && !trc_busy) ? CMD_WRITE : CMD_NOP;
            cyc++;
            @(negedge clk);
        end
        user_req.cmd = CMD_NOP;
        checks++;
        assert (!bist_busy) else begin
            $display("self-test still running after %0d cycles", cyc);
            errors++;
        end
        bist_enable = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        logic [DATA_W-1:0]   rd;
        logic [DATA_W-1:0]   old_word;
        logic [ADDR_X_W-1:0] xs [N_RW];
        logic [ADDR_Y_W-1:0] ys [N_RW];
        int                  busy_n;
        int                  set_n;
        int                  reset_n;
        clk          = 1'b0;
        arst_n       = 1'b0;
        user_req     = '0;
        bist_enable  = 1'b0;
        stuck        = 1'b0;
        rng_state    = 32'h311f;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        tests_failed = 0;
        err_mark     = 0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        check_value("rri_o.RST", rri.RST, 1'b1);  // no clock since release yet
        @(negedge clk);
        check_value("rri_o.RST", rri.RST, 1'b0);
        check_value("strobes SET,RESET,READ,AE,XE,YE,CE",
                    {rri.SET, rri.RESET, rri.READ, rri.AE, rri.XE, rri.YE, rri.CE}, '0);
        check_value("trc_busy_o", trc_busy, 1'b0);
        check_value("trc_dout_ready_o", trc_dout_ready, 1'b0);
        check_value("bist_busy_o", bist_busy, 1'b0);
        check_value("bist_fail_o", bist_fail, 1'b0);
        end_test("reset values");

        for (int i = 0; i < N_RW; i++) begin
            xs[i] = ADDR_X_W'(next_rand() % 64);
            ys[i] = ADDR_Y_W'(next_rand());
            access(CMD_WRITE, xs[i], ys[i], rand_word(), rd, busy_n, set_n, reset_n);
        end
        for (int i = 0; i < N_RW; i++) begin
            access(CMD_READ, xs[i], ys[i], '0, rd, busy_n, set_n, reset_n);
            check_value("trc_dout_o", rd, expected_word(xs[i], ys[i]));
        end
        end_test("random write and read back");

        for (int i = 0; i < N_TIMING; i++) begin
            access(CMD_WRITE, ADDR_X_W'(next_rand()), ADDR_Y_W'(next_rand()), rand_word(),
                   rd, busy_n, set_n, reset_n);
            check_value("trc_busy_o cycles", busy_n, WR_BUSY);
            check_value("rri_o.SET cycles", set_n, PHASE_CYC);
            check_value("rri_o.RESET cycles", reset_n, PHASE_CYC);
        end
        end_test("write phase timing");

        run_bist(1'b0, '0, '0);
        check_value("bist_fail_o", bist_fail, 1'b0);
        for (int a = 0; a < BIST_DEPTH; a++) begin
            ref_mem[{ADDR_X_W'(a), ADDR_Y_W'(0)}] = bist_pattern(a);
            access(CMD_READ, ADDR_X_W'(a), '0, '0, rd, busy_n, set_n, reset_n);
            check_value("trc_dout_o", rd, bist_pattern(a));
        end
        end_test("self-test on a good macro");

        stuck = 1'b1;
        run_bist(1'b0, '0, '0);
        check_value("bist_fail_o", bist_fail, 1'b1);
        stuck = 1'b0;
        end_test("self-test with a stuck bit");

        old_word = rand_word();
        access(CMD_WRITE, 13'd200, 5'd9, old_word, rd, busy_n, set_n, reset_n);
        run_bist(1'b1, 13'd200, 5'd9);
        access(CMD_READ, 13'd200, 5'd9, '0, rd, busy_n, set_n, reset_n);
        check_value("trc_dout_o", rd, expected_word(13'd200, 5'd9));
        end_test("user writes dropped during self-test");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // 20 cycles per access is far above the slowest read
    initial begin
        #(CLK_PERIOD * (TOTAL_OPS * 20 + 10));
        $display("watchdog ran out after %0d cycles, run stopped", TOTAL_OPS * 20 + 10);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/rram_pkg.sv
logic/rram_req_arbiter.sv
logic/rram_access_ctrl.sv
logic/rram_bist_engine.sv
logic/rram_wrapper.sv
verification/rram_macro_model.sv
verification/tb_rram_wrapper.sv
